//--- common/proof_if.sv
`timescale 1ns/1ps

// challenges from the packet parser to the sequencer
interface chal_if import proof_pkg::*; ();
	logic    start;          // one cycle pulse
	logic    pmod;           // 1: 6 challenges, 64 scalars
	scalar_t chal [MAX_CHAL];
	logic    busy;

	modport rx (output start, output pmod, output chal, input busy);
	modport ctrl (input start, input pmod, input chal, output busy);
endinterface

// request port of the shared exponent/multiply unit
interface fexp_if import proof_pkg::*; ();
	logic    estr;  // one cycle pulse
	logic    mode;  // 0 exp, 1 mul
	scalar_t data;
	scalar_t expo;
	logic    eend;  // one cycle pulse
	scalar_t dexp;

	modport ctrl (
		output estr, output mode, output data, output expo,
		input  eend, input  dexp
	);
	modport unit (
		input  estr, input  mode, input  data, input  expo,
		output eend, output dexp
	);
endinterface

// read side of the scalar store
interface scalar_if import proof_pkg::*; ();
	logic      send;     // vector complete
	scal_idx_t last_idx; // n-1
	scalar_t   rd_data;  // comb on rd_idx
	scal_idx_t rd_idx;
	logic      done;     // last beat gone

	modport ctrl (output send, output last_idx, output rd_data, input rd_idx, input done);
	modport tx (input send, input last_idx, input rd_data, output rd_idx, output done);
endinterface

//--- common/proof_pkg.sv
package proof_pkg;

	// stream beat width, same on both AXI-stream sides
	localparam int DATA_W = 64;

	typedef logic [63:0] scalar_t; // one field element

	// mersenne prime 2^61-1
	localparam scalar_t GROUP_ORDER = 64'h1FFF_FFFF_FFFF_FFFF;
	localparam scalar_t GORDER_SUB2 = 64'h1FFF_FFFF_FFFF_FFFD; // fermat inversion exponent

	localparam int MAX_CHAL = 6;  // pmod=1
	localparam int MAX_SCAL = 64; // 2^MAX_CHAL

	typedef logic [2:0] chal_idx_t;
	typedef logic [5:0] scal_idx_t;

	// scalar vector sequencer
	typedef enum logic [2:0]
	{
		ST_OIDLE, // idle
		ST_OEXP1, // s0 = s0**GORDER_SUB2
		ST_OREDY, // derive j and i-2^j
		ST_OEXPO, // t = x[k-1-j]**2
		ST_OMULT, // s[i] = t*s[i-2^j], also the challenge fold into s0
		ST_OSEND  // hand the vector to the output side
	} oexp_state_t;

endpackage

//--- dv/proof_patterns.txt
// proof packets, nine hex words each
// pmod, six challenge words (unused ones zero), expected s[0], expected s[n-1]
// challenges are powers of two or their negatives mod 2^61-1,
// so s[0] is a signed power of two and s[n-1] is the challenge product

// packet 0: five challenges, product -(2^2)
0000000000000000
0000000000000008 0000000000020000 0000010000000000
1FFFFFFFFFFFFFDF 0800000000000000 0000000000000000
17FFFFFFFFFFFFFF
1FFFFFFFFFFFFFFB

// packet 1: six challenges, product 2^31
0000000000000001
0000000000000002 1000000000000000 1FFFFFFFBFFFFFFF
1FFFFFFFFFFFFF7F 0000000000000800 0000100000000000
0000000040000000
0000000080000000

// packet 2: five challenges, product -(2^55)
0000000000000000
1FFFFFFFFFFFFFFE 0000000200000000 0000000000100000
1FFBFFFFFFFFFFFF 1FFFFFFFFFFFDFFF 0000000000000000
1FFFFFFFFFFFFFBF
1F7FFFFFFFFFFFFF

//--- dv/proof_tb.sv
`timescale 1ns/1ps

module proof_tb import proof_pkg::*; ();

	localparam int NUM_PKT    = 3;
	localparam int REC_W      = 9;   // words per packet record in the pattern file
	localparam int CLK_PERIOD = 8;
	localparam int MUL_CYC    = 72;  // 64-cycle multiply plus handshake slack

	logic              clk;
	logic              arst_n;
	logic              axi_valid_i;
	logic              axi_tlast_i;
	logic [DATA_W-1:0] axi_tdata_i;
	logic              axi_ready_o;
	logic              axi_valid_o;
	logic              axi_ready_i;
	logic              axi_tlast_o;
	logic [DATA_W-1:0] axi_tdata_o;

	scalar_t pat_mem [NUM_PKT*REC_W];
	scalar_t exp_vec [NUM_PKT][MAX_SCAL]; // model vectors
	int      exp_len [NUM_PKT];
	int      seed        = 91227;
	int      errors      = 0;
	int      beats       = 0;
	int      out_pkt     = 0;
	int      out_beat    = 0;
	logic    model_ready = 1'b0;
	logic    bp_en       = 1'b0;   // output back-pressure on
	logic    in_gap;
	logic    ready_nxt;
	logic    in_flight   = 1'b0;   // tlast taken, output not yet complete
	logic    stall_q     = 1'b0;
	scalar_t stall_data  = '0;
	logic    stall_last  = 1'b0;
	longint  wd_cycles;

	proof_top i_proof_top (
		.clk_i       (clk),
		.arst_ni     (arst_n),
		.axi_valid_i (axi_valid_i),
		.axi_ready_o (axi_ready_o),
		.axi_tlast_i (axi_tlast_i),
		.axi_tdata_i (axi_tdata_i),
		.axi_valid_o (axi_valid_o),
		.axi_ready_i (axi_ready_i),
		.axi_tlast_o (axi_tlast_o),
		.axi_tdata_o (axi_tdata_o)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	function automatic scalar_t mul_mod(scalar_t a, scalar_t b);
		logic [127:0] prod;
		prod = {64'd0, a} * {64'd0, b};
		return scalar_t'(prod % {64'd0, GROUP_ORDER});
	endfunction

	// left to right square and multiply
	function automatic scalar_t pow_mod(scalar_t b, scalar_t e);
		scalar_t r;
		r = scalar_t'(1);
		for (int i = 63; i >= 0; i--)
		begin
			r = mul_mod(r, r);
			if (e[i])
				r = mul_mod(r, b);
		end
		return r;
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("Fail at %0t: %s", $time, msg);
	endtask

	task automatic build_model(input int p);
		int      k;
		int      n;
		int      j;
		scalar_t x [MAX_CHAL];
		scalar_t prod;
		k    = pat_mem[p*REC_W][0] ? 6 : 5;
		n    = 1 << k;
		prod = scalar_t'(1);
		for (int c = 0; c < k; c++)
		begin
			x[c] = pat_mem[p*REC_W+1+c];
			prod = mul_mod(prod, x[c]);
		end
		exp_vec[p][0] = pow_mod(prod, GROUP_ORDER - 64'd2);  // inverse of the product
		for (int i = 1; i < n; i++)
		begin
			j = 0;
			for (int b = 0; b < 6; b++)
				if (i[b])
					j = b;
			exp_vec[p][i] = mul_mod(exp_vec[p][i - (1 << j)], mul_mod(x[k-1-j], x[k-1-j]));
		end
		exp_len[p] = n;
		if (exp_vec[p][0] != pat_mem[p*REC_W+7])
			flag_error($sformatf("packet %0d model s[0] %h differs from file %h",
				p, exp_vec[p][0], pat_mem[p*REC_W+7]));
		if (exp_vec[p][n-1] != pat_mem[p*REC_W+8])
			flag_error($sformatf("packet %0d model s[%0d] %h differs from file %h",
				p, n - 1, exp_vec[p][n-1], pat_mem[p*REC_W+8]));
	endtask

	// called at posedge+1, leaves at posedge+1 after the transfer
	task automatic drive_beat(input scalar_t data, input logic last);
		logic taken;
		while (in_gap)
		begin
			@(posedge clk);
			#1;
		end
		axi_valid_i = 1'b1;
		axi_tdata_i = data;
		axi_tlast_i = last;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = axi_ready_o;
		end
		@(posedge clk);
		#1;
		axi_valid_i = 1'b0;
		axi_tlast_i = 1'b0;
	endtask

	task automatic send_packet(input int p);
		int k;
		k = pat_mem[p*REC_W][0] ? 6 : 5;
		for (int b = 0; b <= k; b++)
			drive_beat(pat_mem[p*REC_W+b], b == k);  // mode beat, then challenges
	endtask

	task automatic check_beat();
		scalar_t expect_val;
		int      last;
		if (out_pkt >= NUM_PKT)
			flag_error("output beat after the last packet");
		else
		begin
			expect_val = exp_vec[out_pkt][out_beat];
			last       = exp_len[out_pkt] - 1;
			if (axi_tdata_o != expect_val)
				flag_error($sformatf("packet %0d beat %0d: got %h expected %h",
					out_pkt, out_beat, axi_tdata_o, expect_val));
			if (axi_tlast_o != (out_beat == last))
				flag_error($sformatf("packet %0d beat %0d: tlast %0b", out_pkt, out_beat,
					axi_tlast_o));
			if (out_beat == 0 && axi_tdata_o != pat_mem[out_pkt*REC_W+7])
				flag_error($sformatf("packet %0d: s[0] differs from file", out_pkt));
			if (out_beat == last && axi_tdata_o != pat_mem[out_pkt*REC_W+8])
				flag_error($sformatf("packet %0d: s[%0d] differs from file", out_pkt, last));
			beats++;
			if (out_beat == last)
			begin
				out_beat  = 0;
				out_pkt   = out_pkt + 1;
				in_flight = 1'b0;
				bp_en     = 1'b1;  // later packets see random ready gaps
			end
			else
				out_beat = out_beat + 1;
		end
	endtask

	// gap and ready decisions, consumed one edge later
	initial
	begin
		in_gap    = 1'b0;
		ready_nxt = 1'b1;
		forever
		begin
			@(negedge clk);
			in_gap    <= (($random(seed) & 3) == 0);
			ready_nxt <= (($random(seed) & 3) != 0);
		end
	end

	initial
	begin
		axi_ready_i = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			axi_ready_i = bp_en ? ready_nxt : 1'b1;
		end
	end

	// all stream checks on the falling edge
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			if (in_flight && axi_ready_o)
				flag_error("input ready while a packet is still in flight");
			if (axi_valid_i && axi_ready_o && axi_tlast_i)
				in_flight = 1'b1;
			if (stall_q && (!axi_valid_o || axi_tdata_o != stall_data
				|| axi_tlast_o != stall_last))
				flag_error("output beat changed while ready was low");
			stall_q    = axi_valid_o && !axi_ready_i;
			stall_data = axi_tdata_o;
			stall_last = axi_tlast_o;
			if (axi_valid_o && axi_ready_i)
				check_beat();
		end
	end

	initial
	begin
		wait (model_ready);
		wd_cycles = 10;
		for (int p = 0; p < NUM_PKT; p++)
		begin
			// fold, inversion, then a square and a product per scalar
			wd_cycles += longint'(exp_len[p] + 64 + $countones(GROUP_ORDER - 64'd2)
				+ 2 * (exp_len[p] - 1)) * MUL_CYC;
			wd_cycles += 8 * (exp_len[p] + MAX_CHAL + 1);
		end
		wd_cycles = 2 * wd_cycles;
		#(wd_cycles * CLK_PERIOD);
		$display("timeout: output incomplete after %0d cycles, %0d beats seen", wd_cycles, beats);
		$display("test failed");
		$finish;
	end

	initial
	begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		axi_valid_i = 1'b0;
		axi_tlast_i = 1'b0;
		axi_tdata_i = '0;
		$readmemh("dv/proof_patterns.txt", pat_mem);
		for (int p = 0; p < NUM_PKT; p++)
			build_model(p);
		model_ready = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		if (!axi_ready_o || axi_valid_o)
			flag_error($sformatf("after reset ready %0b valid %0b", axi_ready_o, axi_valid_o));
		@(posedge clk);
		#1;
		for (int p = 0; p < NUM_PKT; p++)
			send_packet(p);  // third one queues behind the second
		wait (out_pkt == NUM_PKT);
		repeat (8) @(posedge clk);
		$display("errors: %0d, output beats checked: %0d, packets: %0d", errors, beats, out_pkt);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- files.f
common/proof_pkg.sv
common/proof_if.sv
source/proof_rx.sv
scalar/field_mul.sv
scalar/field_exp_mul.sv
scalar/expo_ctrl.sv
source/scalar_tx.sv
source/proof_top.sv
dv/proof_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build proof_tb with Verilator, run it, pass only when the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module proof_tb -f files.f -o proof_sim &&
./obj_dir/proof_sim | tee /dev/stderr | grep -q "test passed" &&
echo "run_sim: simulation ok" ||
{ echo "run_sim: simulation did not pass"; exit 1; }

//--- scalar/expo_ctrl.sv
`timescale 1ns/1ps

module expo_ctrl import proof_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_ni,
	chal_if.ctrl    chal,
	fexp_if.ctrl    fexp,
	scalar_if.ctrl  scal
);

	oexp_state_t state;
	scalar_t     store [MAX_SCAL];   // s[0..n-1]
	chal_idx_t   cidx;               // fold position
	scal_idx_t   scnt;               // i, also the write index
	scal_idx_t   base_idx;           // i - 2^j
	chal_idx_t   num_chal;
	scal_idx_t   last_idx;
	chal_idx_t   hsb;                // j
	chal_idx_t   xsel;               // k-1-j
	scal_idx_t   base;
	logic        estr_q;
	logic        mode_q;
	logic        send_q;
	scalar_t     op_a;
	scalar_t     op_b;
	logic        issue;
	logic        nxt_mode;
	scalar_t     nxt_a;
	scalar_t     nxt_b;
	logic        req_open;

	assign num_chal = chal.pmod ? chal_idx_t'(MAX_CHAL) : chal_idx_t'(MAX_CHAL - 1);
	assign last_idx = chal.pmod ? scal_idx_t'(MAX_SCAL - 1) : scal_idx_t'(MAX_SCAL / 2 - 1);

	// highest set bit of i
	always_comb
	begin
		hsb = '0;
		for (int b = 0; b < 6; b++)
		begin
			if (scnt[b])
				hsb = chal_idx_t'(b);
		end
	end

	assign base = scnt - (scal_idx_t'(1) << hsb);
	assign xsel = chal_idx_t'(num_chal - 3'd1 - hsb);

	// next request to the shared unit
	always_comb
	begin
		issue    = 1'b0;
		nxt_mode = 1'b1;
		nxt_a    = fexp.dexp;
		nxt_b    = fexp.dexp;
		case (state)
			ST_OIDLE:
			begin
				issue = chal.start;
				nxt_a = scalar_t'(1);
				nxt_b = chal.chal[0];
			end
			ST_OMULT:
			begin
				issue = fexp.eend && scnt == '0;  // fold step or inversion
				if (cidx == num_chal - 3'd1)
				begin
					nxt_mode = 1'b0;
					nxt_b    = GORDER_SUB2;
				end
				else
					nxt_b = chal.chal[chal_idx_t'(cidx + 3'd1)];
			end
			ST_OREDY:
			begin
				issue = 1'b1;
				nxt_a = chal.chal[xsel];
				nxt_b = chal.chal[xsel];
			end
			ST_OEXPO:
			begin
				issue = fexp.eend;
				nxt_b = store[base_idx];
			end
			default:;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_ni)
	begin
		if (!arst_ni)
		begin
			state    <= ST_OIDLE;
			cidx     <= '0;
			scnt     <= '0;
			base_idx <= '0;
			estr_q   <= 1'b0;
			mode_q   <= 1'b1;
			send_q   <= 1'b0;
			req_open <= 1'b0;
		end
		else
		begin
			estr_q   <= issue;
			send_q   <= 1'b0;
			req_open <= estr_q | (req_open & ~fexp.eend);
			if (issue)
				mode_q <= nxt_mode;
			case (state)
				ST_OIDLE:
				begin
					if (chal.start)
					begin
						cidx  <= '0;
						scnt  <= '0;
						state <= ST_OMULT;
					end
				end
				ST_OMULT:
				begin
					if (fexp.eend)
					begin
						if (scnt == '0)
						begin
							if (cidx == num_chal - 3'd1)
								state <= ST_OEXP1;
							else
								cidx <= cidx + 3'd1;
						end
						else if (scnt == last_idx)
						begin
							send_q <= 1'b1;
							state  <= ST_OSEND;
						end
						else
						begin
							scnt  <= scnt + 6'd1;
							state <= ST_OREDY;
						end
					end
				end
				ST_OEXP1:
				begin
					if (fexp.eend)
					begin
						scnt  <= 6'd1;
						state <= ST_OREDY;
					end
				end
				ST_OREDY:
				begin
					base_idx <= base;
					state    <= ST_OEXPO;
				end
				ST_OEXPO:
				begin
					if (fexp.eend)
						state <= ST_OMULT;
				end
				ST_OSEND:
				begin
					if (scal.done)
						state <= ST_OIDLE;
				end
				default: state <= ST_OIDLE;
			endcase
		end
	end

	// operands held until eend
	always_ff @(posedge clk_i)
	begin
		if (issue)
		begin
			op_a <= nxt_a;
			op_b <= nxt_b;
		end
	end

	// s0 fold and inversion also write through scnt, which is 0 then
	always_ff @(posedge clk_i)
	begin
		if (fexp.eend && (state == ST_OMULT || state == ST_OEXP1))
			store[scnt] <= fexp.dexp;
	end

	assign chal.busy     = (state != ST_OIDLE);
	assign fexp.estr     = estr_q;
	assign fexp.mode     = mode_q;
	assign fexp.data     = op_a;
	assign fexp.expo     = op_b;
	assign scal.send     = send_q;
	assign scal.last_idx = last_idx;
	assign scal.rd_data  = store[scal.rd_idx];

	assert property (@(posedge clk_i) disable iff (!arst_ni)
		fexp.estr |-> !req_open);

endmodule

//--- scalar/field_exp_mul.sv
`timescale 1ns/1ps

module field_exp_mul import proof_pkg::*; (
	input  logic  clk_i,
	input  logic  arst_ni,
	fexp_if.unit  fexp
);

	typedef enum logic [1:0] {FE_IDLE, FE_ONE, FE_SQR, FE_MUL} fe_state_t;

	fe_state_t state;
	logic [5:0] bit_idx;    // exponent bit, msb first
	logic       mul_start;
	logic       mul_done;
	scalar_t    mul_a;
	scalar_t    mul_b;
	scalar_t    mul_p;
	logic       load;
	scalar_t    nxt_a;
	scalar_t    nxt_b;
	logic       finish;
	logic       eend_q;
	scalar_t    dexp_q;

	always_comb
	begin
		load  = 1'b0;
		nxt_a = mul_p;
		nxt_b = mul_p;  // square by default
		case (state)
			FE_IDLE:
			begin
				load  = fexp.estr;
				nxt_a = fexp.mode ? fexp.data : scalar_t'(1);
				nxt_b = fexp.mode ? fexp.expo : scalar_t'(1);
			end
			FE_SQR:
			begin
				load = mul_done && (fexp.expo[bit_idx] || bit_idx != '0);
				if (fexp.expo[bit_idx])
					nxt_b = fexp.data;
			end
			FE_MUL: load = mul_done && bit_idx != '0;
			default:;
		endcase
	end

	assign finish = mul_done && (state == FE_ONE ||
		(state == FE_SQR && !fexp.expo[bit_idx] && bit_idx == '0) ||
		(state == FE_MUL && bit_idx == '0));

	always_ff @(posedge clk_i or negedge arst_ni)
	begin
		if (!arst_ni)
		begin
			state     <= FE_IDLE;
			bit_idx   <= '0;
			mul_start <= 1'b0;
			eend_q    <= 1'b0;
		end
		else
		begin
			mul_start <= load;
			eend_q    <= finish;
			case (state)
				FE_IDLE:
				begin
					if (fexp.estr)
					begin
						state   <= fexp.mode ? FE_ONE : FE_SQR;
						bit_idx <= 6'd63;
					end
				end
				FE_ONE:
				begin
					if (mul_done)
						state <= FE_IDLE;
				end
				FE_SQR:
				begin
					if (mul_done)
					begin
						if (fexp.expo[bit_idx])
							state <= FE_MUL;
						else if (bit_idx == '0)
							state <= FE_IDLE;
						else
							bit_idx <= bit_idx - 6'd1;
					end
				end
				FE_MUL:
				begin
					if (mul_done)
					begin
						if (bit_idx == '0)
							state <= FE_IDLE;
						else
						begin
							bit_idx <= bit_idx - 6'd1;
							state   <= FE_SQR;
						end
					end
				end
				default: state <= FE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (load)
		begin
			mul_a <= nxt_a;
			mul_b <= nxt_b;
		end
		if (finish)
			dexp_q <= mul_p;
	end

	field_mul i_field_mul (
		.clk_i   (clk_i),
		.arst_ni (arst_ni),
		.start_i (mul_start),
		.a_i     (mul_a),
		.b_i     (mul_b),
		.done_o  (mul_done),
		.p_o     (mul_p)
	);

	assign fexp.eend = eend_q;
	assign fexp.dexp = dexp_q;

endmodule

//--- scalar/field_mul.sv
`timescale 1ns/1ps

module field_mul import proof_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_ni,
	input  logic    start_i,
	input  scalar_t a_i,
	input  scalar_t b_i,
	output logic    done_o,
	output scalar_t p_o
);

	scalar_t    acc;
	scalar_t    a_q;
	scalar_t    b_q;     // multiplier, shifted out msb first
	logic [5:0] cnt;
	logic       busy;

	// one interleaved step: acc = 2*acc + bit*a mod p
	function automatic scalar_t mod_step(scalar_t acc_in, scalar_t a_in, logic bit_in);
		scalar_t dbl;
		scalar_t sum;
		dbl = acc_in << 1;
		if (dbl >= GROUP_ORDER)
			dbl = dbl - GROUP_ORDER;
		sum = bit_in ? dbl + a_in : dbl;
		if (sum >= GROUP_ORDER)
			sum = sum - GROUP_ORDER;
		return sum;
	endfunction

	always_ff @(posedge clk_i or negedge arst_ni)
	begin
		if (!arst_ni)
		begin
			cnt    <= '0;
			busy   <= 1'b0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= busy && cnt == 6'd62;
			if (start_i)
			begin
				cnt  <= '0;
				busy <= 1'b1;
			end
			else if (busy)
			begin
				cnt <= cnt + 6'd1;
				if (cnt == 6'd62)
					busy <= 1'b0;  // bit 0 done
			end
		end
	end

	// bit 63 is taken on the start edge itself
	always_ff @(posedge clk_i)
	begin
		if (start_i)
		begin
			acc <= mod_step('0, a_i, b_i[63]);
			a_q <= a_i;
			b_q <= b_i << 1;
		end
		else if (busy)
		begin
			acc <= mod_step(acc, a_q, b_q[63]);
			b_q <= b_q << 1;
		end
	end

	assign p_o = acc;

	assert property (@(posedge clk_i) disable iff (!arst_ni)
		start_i |-> (a_i < GROUP_ORDER && b_i < GROUP_ORDER));

endmodule

//--- source/proof_rx.sv
`timescale 1ns/1ps

module proof_rx import proof_pkg::*; (
	input  logic              clk_i,
	input  logic              arst_ni,
	input  logic              axi_valid_i,
	input  logic              axi_tlast_i,
	input  logic [DATA_W-1:0] axi_tdata_i,
	output logic              axi_ready_o,
	chal_if.rx                chal
);

	chal_idx_t beat_cnt;  // 0 is the mode beat
	chal_idx_t num_chal;
	logic      pmod_q;
	logic      start_q;   // pending start, blocks input for one cycle
	logic      accept;

	assign accept      = axi_valid_i & axi_ready_o;
	assign axi_ready_o = ~(chal.busy | start_q);
	assign num_chal    = pmod_q ? chal_idx_t'(MAX_CHAL) : chal_idx_t'(MAX_CHAL - 1);

	assign chal.start = start_q;
	assign chal.pmod  = pmod_q;

	always_ff @(posedge clk_i or negedge arst_ni)
	begin
		if (!arst_ni)
		begin
			beat_cnt <= '0;
			pmod_q   <= 1'b0;
			start_q  <= 1'b0;
		end
		else
		begin
			start_q <= accept & axi_tlast_i;
			if (accept)
			begin
				if (beat_cnt == '0)
					pmod_q <= axi_tdata_i[0];
				beat_cnt <= axi_tlast_i ? chal_idx_t'(0) : beat_cnt + 3'd1;
			end
		end
	end

	// challenge beats land in the interface array
	always_ff @(posedge clk_i)
	begin
		if (accept && beat_cnt != '0)
			chal.chal[chal_idx_t'(beat_cnt - 3'd1)] <= axi_tdata_i;
	end

	// packet length follows the mode beat
	assert property (@(posedge clk_i) disable iff (!arst_ni)
		accept |-> (axi_tlast_i == (beat_cnt == num_chal)));

	assert property (@(posedge clk_i) disable iff (!arst_ni)
		(accept && beat_cnt != '0) |-> (axi_tdata_i != '0 && axi_tdata_i < GROUP_ORDER));

endmodule

//--- source/proof_top.sv
`timescale 1ns/1ps

module proof_top import proof_pkg::*; (
	input  logic              clk_i,
	input  logic              arst_ni,
	// proof packet in
	input  logic              axi_valid_i,
	output logic              axi_ready_o,
	input  logic              axi_tlast_i,
	input  logic [DATA_W-1:0] axi_tdata_i,
	// scalar vector out
	output logic              axi_valid_o,
	input  logic              axi_ready_i,
	output logic              axi_tlast_o,
	output logic [DATA_W-1:0] axi_tdata_o
);

	chal_if   chal_bus ();
	fexp_if   fexp_bus ();
	scalar_if scal_bus ();

	proof_rx i_proof_rx (
		.clk_i       (clk_i),
		.arst_ni     (arst_ni),
		.axi_valid_i (axi_valid_i),
		.axi_tlast_i (axi_tlast_i),
		.axi_tdata_i (axi_tdata_i),
		.axi_ready_o (axi_ready_o),
		.chal        (chal_bus)
	);

	expo_ctrl i_expo_ctrl (
		.clk_i   (clk_i),
		.arst_ni (arst_ni),
		.chal    (chal_bus),
		.fexp    (fexp_bus),
		.scal    (scal_bus)
	);

	// shared exp/mul unit
	field_exp_mul i_field_exp_mul (
		.clk_i   (clk_i),
		.arst_ni (arst_ni),
		.fexp    (fexp_bus)
	);

	scalar_tx i_scalar_tx (
		.clk_i       (clk_i),
		.arst_ni     (arst_ni),
		.scal        (scal_bus),
		.axi_valid_o (axi_valid_o),
		.axi_tlast_o (axi_tlast_o),
		.axi_tdata_o (axi_tdata_o),
		.axi_ready_i (axi_ready_i)
	);

endmodule

//--- source/scalar_tx.sv
`timescale 1ns/1ps

module scalar_tx import proof_pkg::*; (
	input  logic              clk_i,
	input  logic              arst_ni,
	scalar_if.tx              scal,
	output logic              axi_valid_o,
	output logic              axi_tlast_o,
	output logic [DATA_W-1:0] axi_tdata_o,
	input  logic              axi_ready_i
);

	scal_idx_t idx;
	logic      active;
	logic      done_q;
	logic      is_last;

	assign is_last = (idx == scal.last_idx);

	always_ff @(posedge clk_i or negedge arst_ni)
	begin
		if (!arst_ni)
		begin
			idx    <= '0;
			active <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (scal.send)
			begin
				idx    <= '0;
				active <= 1'b1;
			end
			else if (active && axi_ready_i)
			begin
				if (is_last)
				begin
					active <= 1'b0;
					done_q <= 1'b1;  // releases the sequencer
				end
				else
					idx <= idx + 6'd1;
			end
		end
	end

	assign scal.rd_idx = idx;
	assign scal.done   = done_q;
	assign axi_valid_o = active;
	assign axi_tlast_o = active & is_last;
	assign axi_tdata_o = scal.rd_data;  // store is frozen until done

	// beat held across back-pressure, store included
	assert property (@(posedge clk_i) disable iff (!arst_ni)
		(axi_valid_o && !axi_ready_i) |=> (axi_valid_o && $stable(axi_tdata_o)
			&& $stable(axi_tlast_o)));

endmodule
